// File: riscv_em_pkg.sv
package riscv_em_pkg;

    localparam int XLEN = 64;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // alu funct3 and funct7 values
    localparam logic [2:0] F3_ADD   = 3'b000;
    localparam logic [2:0] F3_XOR   = 3'b100;
    localparam logic [2:0] F3_OR    = 3'b110;
    localparam logic [2:0] F3_AND   = 3'b111;
    localparam logic [6:0] F7_BASE  = 7'b0000000;
    localparam logic [6:0] F7_SUB   = 7'b0100000;

    // load extension, same encoding as load funct3
    localparam logic [2:0] MEMEXT_B  = 3'b000;
    localparam logic [2:0] MEMEXT_H  = 3'b001;
    localparam logic [2:0] MEMEXT_W  = 3'b010;
    localparam logic [2:0] MEMEXT_D  = 3'b011;
    localparam logic [2:0] MEMEXT_BU = 3'b100;
    localparam logic [2:0] MEMEXT_HU = 3'b101;
    localparam logic [2:0] MEMEXT_WU = 3'b110;

    localparam logic [1:0] STORESRC_B = 2'b00;
    localparam logic [1:0] STORESRC_H = 2'b01;
    localparam logic [1:0] STORESRC_W = 2'b10;
    localparam logic [1:0] STORESRC_D = 2'b11;

    localparam logic [2:0] RESULTSRC_ALU  = 3'b000;
    localparam logic [2:0] RESULTSRC_LOAD = 3'b001;

    // mcause values
    localparam logic [3:0] TRAP_ILLEGAL          = 4'd2;
    localparam logic [3:0] TRAP_LOAD_MISALIGNED  = 4'd4;
    localparam logic [3:0] TRAP_STORE_MISALIGNED = 4'd6;

    localparam int DMEM_WORDS = 32;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    typedef struct packed {
        logic [11:0] imm12;   // funct7 in the top 7 bits for R-type
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } riscv_em_itype_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } riscv_em_stype_t;

    typedef union packed {
        riscv_em_itype_t i_view;
        riscv_em_stype_t s_view;
    } riscv_em_inst_u;

endpackage

// File: riscv_em_if.sv
interface riscv_em_if;
    import riscv_em_pkg::*;

    logic            instret;            // one real instruction
    logic            regw;
    logic [2:0]      resultsrc;
    logic [1:0]      storesrc;
    logic [2:0]      memext;
    logic [XLEN-1:0] result;             // alu value or memory address
    logic [XLEN-1:0] storedata;
    logic [4:0]      rdaddr;
    logic [XLEN-1:0] pc;
    logic            illegal_inst;
    logic            load_misaligned;
    logic            store_misaligned;

    modport producer (
        output instret,
        output regw,
        output resultsrc,
        output storesrc,
        output memext,
        output result,
        output storedata,
        output rdaddr,
        output pc,
        output illegal_inst,
        output load_misaligned,
        output store_misaligned
    );

    modport consumer (
        input  instret,
        input  regw,
        input  resultsrc,
        input  storesrc,
        input  memext,
        input  result,
        input  storedata,
        input  rdaddr,
        input  pc,
        input  illegal_inst,
        input  load_misaligned,
        input  store_misaligned
    );

endinterface

// File: riscv_em_execute.sv
module riscv_em_execute (
    input  logic                          i_riscv_em_valid,
    input  riscv_em_pkg::riscv_em_inst_u  i_riscv_em_inst,
    input  logic [riscv_em_pkg::XLEN-1:0] i_riscv_em_pc,
    input  logic [riscv_em_pkg::XLEN-1:0] i_riscv_em_rs1data,
    input  logic [riscv_em_pkg::XLEN-1:0] i_riscv_em_rs2data,
    riscv_em_if.producer                  ex_bus
);
    import riscv_em_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] alu_out;
    logic [2:0]      align_mask;
    logic            f3_alu_ok;
    logic            regw;
    logic            illegal;
    logic            is_load;
    logic            is_store;
    logic            misaligned;

    function automatic logic [XLEN-1:0] alu_calc(
        input logic [2:0]      f3,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [XLEN-1:0] r;
        case (f3)
            F3_XOR:  r = a ^ b;
            F3_OR:   r = a | b;
            F3_AND:  r = a & b;
            default: r = a + b;
        endcase
        return r;
    endfunction

    assign opcode    = i_riscv_em_inst.i_view.opcode;
    assign funct3    = i_riscv_em_inst.i_view.funct3;
    assign funct7    = i_riscv_em_inst.i_view.imm12[11:5];
    assign imm_i     = {{(XLEN-12){i_riscv_em_inst.i_view.imm12[11]}},
                        i_riscv_em_inst.i_view.imm12};
    assign imm_s     = {{(XLEN-12){i_riscv_em_inst.s_view.imm_hi[6]}},
                        i_riscv_em_inst.s_view.imm_hi, i_riscv_em_inst.s_view.imm_lo};
    assign f3_alu_ok = (funct3 == F3_ADD) || (funct3 == F3_XOR) ||
                       (funct3 == F3_OR) || (funct3 == F3_AND);

    always_comb
    begin
        regw              = 1'b0;
        illegal           = 1'b0;
        is_load           = 1'b0;
        is_store          = 1'b0;
        alu_out           = '0;
        ex_bus.resultsrc  = RESULTSRC_ALU;
        ex_bus.memext     = MEMEXT_B;
        ex_bus.storesrc   = STORESRC_B;
        case (opcode)
            OPC_OP:
            begin
                if (f3_alu_ok && funct7 == F7_BASE)
                begin
                    regw    = 1'b1;
                    alu_out = alu_calc(funct3, i_riscv_em_rs1data, i_riscv_em_rs2data);
                end
                else if (funct3 == F3_ADD && funct7 == F7_SUB)
                begin
                    regw    = 1'b1;
                    alu_out = i_riscv_em_rs1data - i_riscv_em_rs2data;
                end
                else
                    illegal = 1'b1;
            end
            OPC_OP_IMM:
            begin
                regw    = f3_alu_ok;
                illegal = !f3_alu_ok;
                alu_out = alu_calc(funct3, i_riscv_em_rs1data, imm_i);
            end
            OPC_LOAD:
            begin
                is_load          = (funct3 != 3'b111);   // no ldu
                regw             = is_load;
                illegal          = !is_load;
                alu_out          = i_riscv_em_rs1data + imm_i;
                ex_bus.resultsrc = RESULTSRC_LOAD;
                ex_bus.memext    = funct3;
            end
            OPC_STORE:
            begin
                is_store        = !funct3[2];
                illegal         = funct3[2];
                alu_out         = i_riscv_em_rs1data + imm_s;
                ex_bus.storesrc = funct3[1:0];
            end
            default:
                illegal = 1'b1;
        endcase
    end

    // byte, half, word, double all encoded in funct3[1:0]
    always_comb
    begin
        case (funct3[1:0])
            2'b00:   align_mask = 3'b000;
            2'b01:   align_mask = 3'b001;
            2'b10:   align_mask = 3'b011;
            default: align_mask = 3'b111;
        endcase
    end

    assign misaligned = |(alu_out[2:0] & align_mask);

    assign ex_bus.instret          = i_riscv_em_valid;
    assign ex_bus.regw             = regw;
    assign ex_bus.result           = alu_out;
    assign ex_bus.storedata        = i_riscv_em_rs2data;
    assign ex_bus.rdaddr           = i_riscv_em_inst.i_view.rd;
    assign ex_bus.pc               = i_riscv_em_pc;
    assign ex_bus.illegal_inst     = illegal;
    assign ex_bus.load_misaligned  = is_load & misaligned;
    assign ex_bus.store_misaligned = is_store & misaligned;

endmodule

// File: riscv_em_ppreg.sv
module riscv_em_ppreg (
    input  logic          i_riscv_em_clk,
    input  logic          i_riscv_em_rst,
    input  logic          i_riscv_em_stall,
    input  logic          i_riscv_em_flush,
    riscv_em_if.consumer  ex_bus,
    riscv_em_if.producer  mem_bus
);

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin : em_ppreg_proc
        if (i_riscv_em_rst)
        begin
            mem_bus.instret          <= 1'b0;
            mem_bus.regw             <= 1'b0;
            mem_bus.resultsrc        <= '0;
            mem_bus.storesrc         <= '0;
            mem_bus.memext           <= '0;
            mem_bus.result           <= '0;
            mem_bus.storedata        <= '0;
            mem_bus.rdaddr           <= '0;
            mem_bus.pc               <= '0;
            mem_bus.illegal_inst     <= 1'b0;
            mem_bus.load_misaligned  <= 1'b0;
            mem_bus.store_misaligned <= 1'b0;
        end
        else if (i_riscv_em_flush)                // wins over stall
        begin
            mem_bus.instret          <= 1'b0;
            mem_bus.regw             <= 1'b0;
            mem_bus.resultsrc        <= '0;
            mem_bus.storesrc         <= '0;
            mem_bus.memext           <= '0;
            mem_bus.result           <= '0;
            mem_bus.storedata        <= '0;
            mem_bus.rdaddr           <= '0;
            mem_bus.pc               <= '0;
            mem_bus.illegal_inst     <= 1'b0;
            mem_bus.load_misaligned  <= 1'b0;
            mem_bus.store_misaligned <= 1'b0;
        end
        else if (i_riscv_em_stall)
        begin
            mem_bus.instret          <= 1'b0;     // held payload retires only once
        end
        else
        begin
            mem_bus.instret          <= ex_bus.instret;
            mem_bus.regw             <= ex_bus.regw;
            mem_bus.resultsrc        <= ex_bus.resultsrc;
            mem_bus.storesrc         <= ex_bus.storesrc;
            mem_bus.memext           <= ex_bus.memext;
            mem_bus.result           <= ex_bus.result;
            mem_bus.storedata        <= ex_bus.storedata;
            mem_bus.rdaddr           <= ex_bus.rdaddr;
            mem_bus.pc               <= ex_bus.pc;
            mem_bus.illegal_inst     <= ex_bus.illegal_inst;
            mem_bus.load_misaligned  <= ex_bus.load_misaligned;
            mem_bus.store_misaligned <= ex_bus.store_misaligned;
        end
    end

endmodule

// File: riscv_em_memstage.sv
module riscv_em_memstage (
    input  logic                          i_riscv_em_clk,
    input  logic                          i_riscv_em_rst,
    riscv_em_if.consumer                  mem_bus,
    output logic                          o_riscv_em_wb_valid,
    output logic [4:0]                    o_riscv_em_wb_rdaddr,
    output logic [riscv_em_pkg::XLEN-1:0] o_riscv_em_wb_data,
    output logic                          o_riscv_em_trap,
    output logic [3:0]                    o_riscv_em_trap_cause,
    output logic [riscv_em_pkg::XLEN-1:0] o_riscv_em_trap_pc
);
    import riscv_em_pkg::*;

    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic [2:0]         byte_off;
    logic [XLEN-1:0]    rd_word;
    logic [XLEN-1:0]    lane;
    logic [XLEN-1:0]    load_data;
    logic [7:0]         size_mask;
    logic [7:0]         byte_en;
    logic [XLEN-1:0]    wr_data;
    logic [XLEN-1:0]    merged;
    logic               any_fault;
    logic               store_en;

    assign word_idx = mem_bus.result[DMEM_AW+2:3];
    assign byte_off = mem_bus.result[2:0];
    assign rd_word  = dmem[word_idx];
    assign lane     = rd_word >> {byte_off, 3'b000};

    always_comb
    begin
        case (mem_bus.memext)
            MEMEXT_B:  load_data = {{(XLEN-8){lane[7]}}, lane[7:0]};
            MEMEXT_H:  load_data = {{(XLEN-16){lane[15]}}, lane[15:0]};
            MEMEXT_W:  load_data = {{(XLEN-32){lane[31]}}, lane[31:0]};
            MEMEXT_D:  load_data = lane;
            MEMEXT_BU: load_data = {{(XLEN-8){1'b0}}, lane[7:0]};
            MEMEXT_HU: load_data = {{(XLEN-16){1'b0}}, lane[15:0]};
            MEMEXT_WU: load_data = {{(XLEN-32){1'b0}}, lane[31:0]};
            default:   load_data = lane;
        endcase
    end

    always_comb
    begin
        case (mem_bus.storesrc)
            STORESRC_B: size_mask = 8'h01;
            STORESRC_H: size_mask = 8'h03;
            STORESRC_W: size_mask = 8'h0f;
            STORESRC_D: size_mask = 8'hff;
            default:    size_mask = 8'h00;
        endcase
        byte_en = size_mask << byte_off;
        wr_data = mem_bus.storedata << {byte_off, 3'b000};
        for (int b = 0; b < 8; b++)
            merged[8*b +: 8] = byte_en[b] ? wr_data[8*b +: 8] : rd_word[8*b +: 8];
    end

    assign any_fault = mem_bus.illegal_inst | mem_bus.load_misaligned |
                       mem_bus.store_misaligned;
    // only a legal store leaves regw clear
    assign store_en  = mem_bus.instret & ~mem_bus.regw & ~any_fault;

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin : dmem_write_proc
        if (i_riscv_em_rst)
        begin
            for (int w = 0; w < DMEM_WORDS; w++)
                dmem[w] <= '0;
        end
        else if (store_en)
        begin
            dmem[word_idx] <= merged;
        end
    end

    assign o_riscv_em_wb_valid  = mem_bus.instret & mem_bus.regw & ~any_fault &
                                  (mem_bus.rdaddr != 5'd0);
    assign o_riscv_em_wb_rdaddr = mem_bus.rdaddr;
    assign o_riscv_em_wb_data   = (mem_bus.resultsrc == RESULTSRC_LOAD) ? load_data
                                                                        : mem_bus.result;

    assign o_riscv_em_trap    = mem_bus.instret & any_fault;
    assign o_riscv_em_trap_pc = mem_bus.pc;

    always_comb
    begin
        if (mem_bus.illegal_inst)                 // illegal first
            o_riscv_em_trap_cause = TRAP_ILLEGAL;
        else if (mem_bus.load_misaligned)
            o_riscv_em_trap_cause = TRAP_LOAD_MISALIGNED;
        else if (mem_bus.store_misaligned)
            o_riscv_em_trap_cause = TRAP_STORE_MISALIGNED;
        else
            o_riscv_em_trap_cause = 4'd0;
    end

endmodule

// File: riscv_em_top.sv
module riscv_em_top (
    input  logic                          i_riscv_em_clk,
    input  logic                          i_riscv_em_rst,
    input  logic                          i_riscv_em_valid,
    input  logic [31:0]                   i_riscv_em_inst,
    input  logic [riscv_em_pkg::XLEN-1:0] i_riscv_em_pc,
    input  logic [riscv_em_pkg::XLEN-1:0] i_riscv_em_rs1data,
    input  logic [riscv_em_pkg::XLEN-1:0] i_riscv_em_rs2data,
    input  logic                          i_riscv_em_stall,
    input  logic                          i_riscv_em_flush,
    output logic                          o_riscv_em_wb_valid,
    output logic [4:0]                    o_riscv_em_wb_rdaddr,
    output logic [riscv_em_pkg::XLEN-1:0] o_riscv_em_wb_data,
    output logic                          o_riscv_em_trap,
    output logic [3:0]                    o_riscv_em_trap_cause,
    output logic [riscv_em_pkg::XLEN-1:0] o_riscv_em_trap_pc
);

    riscv_em_if ex_bus ();
    riscv_em_if mem_bus ();

    riscv_em_execute u_execute (
        .i_riscv_em_valid   (i_riscv_em_valid),
        .i_riscv_em_inst    (i_riscv_em_inst),
        .i_riscv_em_pc      (i_riscv_em_pc),
        .i_riscv_em_rs1data (i_riscv_em_rs1data),
        .i_riscv_em_rs2data (i_riscv_em_rs2data),
        .ex_bus             (ex_bus.producer)
    );

    riscv_em_ppreg u_ppreg (
        .i_riscv_em_clk   (i_riscv_em_clk),
        .i_riscv_em_rst   (i_riscv_em_rst),
        .i_riscv_em_stall (i_riscv_em_stall),
        .i_riscv_em_flush (i_riscv_em_flush),
        .ex_bus           (ex_bus.consumer),
        .mem_bus          (mem_bus.producer)
    );

    riscv_em_memstage u_memstage (
        .i_riscv_em_clk        (i_riscv_em_clk),
        .i_riscv_em_rst        (i_riscv_em_rst),
        .mem_bus               (mem_bus.consumer),
        .o_riscv_em_wb_valid   (o_riscv_em_wb_valid),
        .o_riscv_em_wb_rdaddr  (o_riscv_em_wb_rdaddr),
        .o_riscv_em_wb_data    (o_riscv_em_wb_data),
        .o_riscv_em_trap       (o_riscv_em_trap),
        .o_riscv_em_trap_cause (o_riscv_em_trap_cause),
        .o_riscv_em_trap_pc    (o_riscv_em_trap_pc)
    );

endmodule

// File: tb_riscv_em_clkgen.sv
module tb_riscv_em_clkgen (
    output logic o_clk,
    output logic o_rst
);

    initial
    begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;      // period 10
    end

    initial
    begin
        o_rst = 1'b1;
        repeat (2) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// File: tb_riscv_em.sv
module tb_riscv_em;
    import riscv_em_pkg::*;

    localparam int N_ALU   = 40;
    localparam int N_MEM   = 16;
    localparam int N_TRAP  = 4;
    localparam int N_TOTAL = N_ALU + 8 * N_MEM + 12 * N_TRAP + 60;   // incl. drain cycles
    localparam int TIMEOUT = N_TOTAL * 10 + 500;

    logic        clk;
    logic        rst;
    logic        valid_r;
    logic [31:0] inst_r;
    logic [63:0] pc_r;
    logic [63:0] rs1_r;
    logic [63:0] rs2_r;
    logic        stall_r;
    logic        flush_r;
    logic        wb_valid;
    logic [4:0]  wb_rdaddr;
    logic [63:0] wb_data;
    logic        trap;
    logic [3:0]  trap_cause;
    logic [63:0] trap_pc;

    // expected outcome of the instruction held in the EX/MEM register
    logic        exp_wb;
    logic [4:0]  exp_rd;
    logic [63:0] exp_data;
    logic        exp_trap;
    logic [3:0]  exp_cause;
    logic [63:0] exp_pc;
    logic        exp_flushed;
    logic [63:0] model_mem [DMEM_WORDS];

    logic [31:0] lfsr = 32'hec4e_ce0f;
    logic [63:0] next_pc;
    int          err_cnt;
    int          n_instr;
    int          n_tests;

    tb_riscv_em_clkgen u_clkgen (
        .o_clk (clk),
        .o_rst (rst)
    );

    riscv_em_top i_riscv_em_top (
        .i_riscv_em_clk        (clk),
        .i_riscv_em_rst        (rst),
        .i_riscv_em_valid      (valid_r),
        .i_riscv_em_inst       (inst_r),
        .i_riscv_em_pc         (pc_r),
        .i_riscv_em_rs1data    (rs1_r),
        .i_riscv_em_rs2data    (rs2_r),
        .i_riscv_em_stall      (stall_r),
        .i_riscv_em_flush      (flush_r),
        .o_riscv_em_wb_valid   (wb_valid),
        .o_riscv_em_wb_rdaddr  (wb_rdaddr),
        .o_riscv_em_wb_data    (wb_data),
        .o_riscv_em_trap       (trap),
        .o_riscv_em_trap_cause (trap_cause),
        .o_riscv_em_trap_pc    (trap_pc)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [2:0] alu_f3(input logic [1:0] sel);
        case (sel)
            2'd0:    return 3'b000;     // add
            2'd1:    return 3'b100;     // xor
            2'd2:    return 3'b110;     // or
            default: return 3'b111;     // and
        endcase
    endfunction

    // clears the offset bits below the access size
    function automatic logic [2:0] align_off(input logic [1:0] sz, input logic [2:0] off);
        return off & (3'b111 << sz);
    endfunction

    // {legal, value} for the supported ALU funct3 codes
    function automatic logic [64:0] alu_ref(input logic [2:0] f3, input logic [63:0] a,
                                            input logic [63:0] b);
        case (f3)
            3'b000:  return {1'b1, a + b};
            3'b100:  return {1'b1, a ^ b};
            3'b110:  return {1'b1, a | b};
            3'b111:  return {1'b1, a & b};
            default: return {1'b0, 64'd0};
        endcase
    endfunction

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        $display("Error %0t %s got %h expected %h", $time, name, got, exp);
        err_cnt++;
    endtask

    task automatic model_accept();
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [63:0] addr;
        logic [63:0] lane;
        logic [63:0] val;
        logic [3:0]  cause;
        logic        ok;
        logic        rd_write;
        logic [4:0]  idx;
        int          nbytes;
        int          off;
        opc      = inst_r[6:0];
        f3       = inst_r[14:12];
        nbytes   = 1 << f3[1:0];
        val      = '0;
        cause    = 4'd0;
        rd_write = 1'b1;
        addr     = rs1_r + ((opc == OPC_STORE) ? sext12({inst_r[31:25], inst_r[11:7]})
                                               : sext12(inst_r[31:20]));
        idx      = addr[7:3];
        off      = int'(addr[2:0]);
        lane     = model_mem[idx] >> (8 * off);
        case (opc)
            OPC_OP:
            begin
                if (inst_r[31:25] == 7'h20 && f3 == 3'b000)
                    val = rs1_r - rs2_r;
                else
                begin
                    {ok, val} = alu_ref(f3, rs1_r, rs2_r);
                    if (!ok || inst_r[31:25] != 7'h00)
                        cause = TRAP_ILLEGAL;
                end
            end
            OPC_OP_IMM:
            begin
                {ok, val} = alu_ref(f3, rs1_r, sext12(inst_r[31:20]));
                if (!ok)
                    cause = TRAP_ILLEGAL;
            end
            OPC_LOAD:
            begin
                case (f3)
                    3'd0:    val = 64'($signed(lane[7:0]));
                    3'd1:    val = 64'($signed(lane[15:0]));
                    3'd2:    val = 64'($signed(lane[31:0]));
                    3'd3:    val = lane;
                    3'd4:    val = 64'(lane[7:0]);
                    3'd5:    val = 64'(lane[15:0]);
                    3'd6:    val = 64'(lane[31:0]);
                    default: cause = TRAP_ILLEGAL;
                endcase
                if (cause == 4'd0 && off % nbytes != 0)
                    cause = TRAP_LOAD_MISALIGNED;
            end
            OPC_STORE:
            begin
                rd_write = 1'b0;
                if (f3[2])
                    cause = TRAP_ILLEGAL;
                else if (off % nbytes != 0)
                    cause = TRAP_STORE_MISALIGNED;
                else
                    for (int i = 0; i < nbytes; i++)
                        model_mem[idx][8 * (off + i) +: 8] = rs2_r[8 * i +: 8];
            end
            default:
                cause = TRAP_ILLEGAL;
        endcase
        exp_wb    <= rd_write && cause == 4'd0 && inst_r[11:7] != 5'd0;
        exp_rd    <= inst_r[11:7];
        exp_data  <= val;
        exp_trap  <= cause != 4'd0;
        exp_cause <= cause;
        exp_pc    <= pc_r;
    endtask

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            exp_wb      <= 1'b0;
            exp_trap    <= 1'b0;
            exp_flushed <= 1'b0;
            for (int w = 0; w < DMEM_WORDS; w++)
                model_mem[w] = '0;
        end
        else
        begin
            exp_flushed <= flush_r;
            if (valid_r && !stall_r && !flush_r)
                model_accept();
            else
            begin
                exp_wb   <= 1'b0;       // bubble, stall or flush
                exp_trap <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) wb_valid == exp_wb)
        else value_error("o_riscv_em_wb_valid", 64'(wb_valid), 64'(exp_wb));
    assert property (@(posedge clk) disable iff (rst) trap == exp_trap)
        else value_error("o_riscv_em_trap", 64'(trap), 64'(exp_trap));
    assert property (@(posedge clk) disable iff (rst) exp_wb |-> wb_rdaddr == exp_rd)
        else value_error("o_riscv_em_wb_rdaddr", 64'(wb_rdaddr), 64'(exp_rd));
    assert property (@(posedge clk) disable iff (rst) exp_wb |-> wb_data == exp_data)
        else value_error("o_riscv_em_wb_data", wb_data, exp_data);
    assert property (@(posedge clk) disable iff (rst) exp_trap |-> trap_cause == exp_cause)
        else value_error("o_riscv_em_trap_cause", 64'(trap_cause), 64'(exp_cause));
    assert property (@(posedge clk) disable iff (rst) exp_trap |-> trap_pc == exp_pc)
        else value_error("o_riscv_em_trap_pc", trap_pc, exp_pc);

    // a flushed register shows an all-zero payload
    assert property (@(posedge clk) disable iff (rst) exp_flushed |-> wb_rdaddr == 5'd0)
        else value_error("o_riscv_em_wb_rdaddr", 64'(wb_rdaddr), 64'd0);
    assert property (@(posedge clk) disable iff (rst) exp_flushed |-> trap_pc == 64'd0)
        else value_error("o_riscv_em_trap_pc", trap_pc, 64'd0);

    task automatic issue(input logic [31:0] inst, input logic [63:0] rs1,
                         input logic [63:0] rs2, input logic stall, input logic flush);
        @(posedge clk);
        valid_r <= 1'b1;
        inst_r  <= inst;
        pc_r    <= next_pc;
        rs1_r   <= rs1;
        rs2_r   <= rs2;
        stall_r <= stall;
        flush_r <= flush;
        next_pc = next_pc + 64'd4;
        n_instr++;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            valid_r <= 1'b0;
            stall_r <= 1'b0;
            flush_r <= 1'b0;
        end
    endtask

    task automatic end_test(input string name);
        idle(3);                    // let the last strobe be checked
        n_tests++;
        $display("test %s finished, %0d instructions so far, %0d failures so far",
                 name, n_instr, err_cnt);
    endtask

    initial
    begin
        logic [31:0] inst;
        logic [63:0] addr;
        logic [63:0] base;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [1:0]  kind;
        valid_r = 1'b0;
        inst_r  = '0;
        pc_r    = '0;
        rs1_r   = '0;
        rs2_r   = '0;
        stall_r = 1'b0;
        flush_r = 1'b0;
        next_pc = 64'h0000_0000_8000_0000;
        err_cnt = 0;
        n_instr = 0;
        n_tests = 0;
        @(negedge rst);
        idle(4);
        end_test("reset");

        for (int k = 0; k < N_ALU; k++)
        begin
            kind = 2'(take_bits(2));
            f3   = alu_f3(2'(take_bits(2)));
            rd   = (k % 10 == 3) ? 5'd0 : 5'(take_bits(5));
            if (kind == 2'd0)
                inst = enc_r(7'h00, f3, rd);
            else if (kind == 2'd1)
                inst = enc_r(7'h20, 3'b000, rd);    // sub
            else
                inst = enc_i(12'(take_bits(12)), f3, rd, OPC_OP_IMM);
            issue(inst, take_bits(64), take_bits(64), 1'b0, 1'b0);
        end
        end_test("alu_ops");

        for (int k = 0; k < N_MEM; k++)
        begin
            f3   = {1'b0, 2'(take_bits(2))};
            base = {56'(take_bits(56)), 5'(take_bits(5)), 3'b000};
            addr = {base[63:3], align_off(f3[1:0], 3'(take_bits(3)))};
            imm  = 12'(take_bits(12));
            issue(enc_s(imm, f3), addr - sext12(imm), take_bits(64), 1'b0, 1'b0);
            for (int w = 0; w < 7; w++)
            begin
                addr = {base[63:3], align_off(2'(w), 3'(take_bits(3)))};
                imm  = 12'(take_bits(12));
                issue(enc_i(imm, 3'(w), 5'(take_bits(5)), OPC_LOAD), addr - sext12(imm),
                      take_bits(64), 1'b0, 1'b0);
            end
        end
        end_test("store_load");

        for (int k = 0; k < N_TRAP; k++)
        begin
            base = {56'(take_bits(56)), 5'(take_bits(5)), 3'b000};
            issue(enc_i(12'd1, 3'b001, 5'd3, OPC_LOAD), base, 64'd0, 1'b0, 1'b0);
            issue(enc_i(12'd2, 3'b010, 5'd4, OPC_LOAD), base, 64'd0, 1'b0, 1'b0);
            issue(enc_i(12'd4, 3'b011, 5'd5, OPC_LOAD), base, 64'd0, 1'b0, 1'b0);
            issue(enc_s(12'd3, 3'b001), base, take_bits(64), 1'b0, 1'b0);
            issue(enc_s(12'd6, 3'b011), base, take_bits(64), 1'b0, 1'b0);
            issue(enc_s(12'd0, 3'b100), base, take_bits(64), 1'b0, 1'b0);    // no such store
            issue(enc_i(12'd0, 3'b111, 5'd6, OPC_LOAD), base, 64'd0, 1'b0, 1'b0);
            issue(enc_r(7'h01, 3'b000, 5'd7), take_bits(64), take_bits(64), 1'b0, 1'b0);
            issue(enc_r(7'h20, 3'b100, 5'd7), take_bits(64), take_bits(64), 1'b0, 1'b0);
            issue(enc_i(12'd5, 3'b001, 5'd8, OPC_OP_IMM), take_bits(64), 64'd0, 1'b0, 1'b0);
            issue(enc_i(12'd0, 3'b000, 5'd9, 7'b1101111), take_bits(64), 64'd0, 1'b0, 1'b0);
            issue(enc_i(12'd0, 3'b011, 5'd10, OPC_LOAD), base, 64'd0, 1'b0, 1'b0);
        end
        end_test("traps");

        // stall plus flush right behind a live load, so a held payload would show
        base = {56'(take_bits(56)), 5'(take_bits(5)), 3'b000};
        issue(enc_i(12'd0, 3'b011, 5'd11, OPC_LOAD), base, 64'd0, 1'b0, 1'b0);
        issue(enc_r(7'h00, 3'b110, 5'd13), take_bits(64), take_bits(64), 1'b1, 1'b1);
        issue(enc_r(7'h00, 3'b000, 5'd12), take_bits(64), take_bits(64), 1'b0, 1'b1);
        issue(enc_s(12'd0, 3'b011), base, take_bits(64), 1'b0, 1'b1);
        issue(enc_i(12'd0, 3'b011, 5'd14, OPC_LOAD), base, 64'd0, 1'b0, 1'b0);
        end_test("flush");

        issue(enc_r(7'h00, 3'b100, 5'd15), take_bits(64), take_bits(64), 1'b0, 1'b0);
        issue(enc_r(7'h00, 3'b111, 5'd16), take_bits(64), take_bits(64), 1'b1, 1'b0);
        issue(enc_s(12'd0, 3'b011), base, take_bits(64), 1'b1, 1'b0);
        issue(enc_i(12'd0, 3'b011, 5'd17, OPC_LOAD), base, 64'd0, 1'b0, 1'b0);
        end_test("stall");

        $display("tests %0d, instructions %0d, failures %0d", n_tests, n_instr, err_cnt);
        if (err_cnt == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        #(TIMEOUT);
        $display("watchdog expired after %0d time units with tests still running", TIMEOUT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: src.f
riscv_em_pkg.sv
riscv_em_if.sv
riscv_em_execute.sv
riscv_em_ppreg.sv
riscv_em_memstage.sv
riscv_em_top.sv
tb_riscv_em_clkgen.sv
tb_riscv_em.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_riscv_em -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_riscv_em)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
